// ==== rtl/main_net_pkg.sv ====
package main_net_pkg;

	localparam int DATA_WIDTH        = 16;
	localparam int FRAC_BITS         = 8; // q7.8 nodes and weights
	localparam int ACC_WIDTH         = 32;
	localparam int N_INPUT           = 2;
	localparam int N_HIDDEN_1        = 4;
	localparam int N_HIDDEN_2        = 4;
	localparam int N_OUTPUT          = 3;
	localparam int NODE_ADDR_WIDTH   = 2;
	localparam int WEIGHT_ADDR_WIDTH = 5; // widest layer holds 20 weights
	localparam int LAYER_WIDTH       = 2;
	localparam int DATA_MAX          = 32767;
	localparam int DATA_MIN          = -32768;

	typedef enum logic [LAYER_WIDTH-1:0] {
		LAYER_INPUT    = 2'd0,
		LAYER_HIDDEN_1 = 2'd1,
		LAYER_HIDDEN_2 = 2'd2,
		LAYER_OUTPUT   = 2'd3
	} layer_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_WAIT_LAYER,
		SEQ_DONE
	} seq_state_e;

	function automatic int unsigned layer_nodes(input layer_e layer);
		case (layer)
			LAYER_INPUT:    return N_INPUT;
			LAYER_HIDDEN_1: return N_HIDDEN_1;
			LAYER_HIDDEN_2: return N_HIDDEN_2;
			default:        return N_OUTPUT;
		endcase
	endfunction

	// node count of the layer feeding this one
	function automatic int unsigned fan_in(input layer_e layer);
		return layer_nodes(layer_e'(layer - 1'b1));
	endfunction

endpackage

// ==== rtl/ff_if.sv ====
interface term_req_if;
	logic                                         valid;
	main_net_pkg::layer_e                         layer;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]     term; // node index in previous layer
	logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]   weight_addr;
	logic                                         bias;
	logic                                         last; // final term of a neuron

	modport seq (
		output valid, layer, term, weight_addr, bias, last
	);

	modport mem (
		input valid, layer, term, weight_addr, bias, last
	);
endinterface

interface term_rsp_if;
	logic                                   valid;
	main_net_pkg::layer_e                   layer;
	logic [main_net_pkg::DATA_WIDTH-1:0]    node_value;
	logic [main_net_pkg::DATA_WIDTH-1:0]    weight;
	logic                                   bias;
	logic                                   last;

	modport mem (
		output valid, layer, node_value, weight, bias, last
	);

	modport acc (
		input valid, layer, node_value, weight, bias, last
	);
endinterface

interface node_wr_if;
	logic                                       valid;
	main_net_pkg::layer_e                       layer;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]   addr;
	logic [main_net_pkg::DATA_WIDTH-1:0]        data;

	modport acc (
		output valid, layer, addr, data
	);

	modport mem (
		input valid, layer, addr, data
	);

	// arg-max only watches
	modport mon (
		input valid, layer, addr, data
	);
endinterface

// ==== rtl/ann_memory.sv ====
module ann_memory (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        i_weight_valid,
	input  logic                                        i_rw_weight_select,
	input  logic [main_net_pkg::LAYER_WIDTH-1:0]        i_weight_layer,
	input  logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]  i_weight_addr,
	input  logic [main_net_pkg::DATA_WIDTH-1:0]         i_weight,
	input  logic                                        i_data_valid,
	input  logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]    i_data_addr,
	input  logic [main_net_pkg::DATA_WIDTH-1:0]         i_data,
	output logic                                        o_weight_valid,
	output logic [main_net_pkg::LAYER_WIDTH-1:0]        o_weight_layer,
	output logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]  o_weight_addr,
	output logic [main_net_pkg::DATA_WIDTH-1:0]         o_weight,
	term_req_if.mem                                     req,
	term_rsp_if.mem                                     rsp,
	node_wr_if.mem                                      wr
);

	logic [main_net_pkg::DATA_WIDTH-1:0] weight_ram
		[2**main_net_pkg::LAYER_WIDTH][2**main_net_pkg::WEIGHT_ADDR_WIDTH];
	logic [main_net_pkg::DATA_WIDTH-1:0] node_ram
		[2**main_net_pkg::LAYER_WIDTH][2**main_net_pkg::NODE_ADDR_WIDTH];
	logic [main_net_pkg::LAYER_WIDTH-1:0] prev_layer;

	assign prev_layer = req.layer - 1'b1; // terms read the layer below

	// select high reads the weight port and low writes it
	always_ff @(posedge clk) begin
		if (i_weight_valid && !i_rw_weight_select) begin
			weight_ram[i_weight_layer][i_weight_addr] <= i_weight;
		end
		if (i_weight_valid && i_rw_weight_select) begin
			o_weight <= weight_ram[i_weight_layer][i_weight_addr];
		end
		o_weight_layer <= i_weight_layer;
		o_weight_addr  <= i_weight_addr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_weight_valid <= 1'b0;
		end else begin
			o_weight_valid <= i_weight_valid && i_rw_weight_select;
		end
	end

	always_ff @(posedge clk) begin
		if (i_data_valid) begin
			node_ram[main_net_pkg::LAYER_INPUT][i_data_addr] <= i_data;
		end
		if (wr.valid) begin
			node_ram[wr.layer][wr.addr] <= wr.data; // neuron result
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp.valid <= 1'b0;
		end else begin
			rsp.valid <= req.valid;
		end
	end

	always_ff @(posedge clk) begin
		rsp.layer      <= req.layer;
		rsp.node_value <= node_ram[prev_layer][req.term];
		rsp.weight     <= weight_ram[req.layer][req.weight_addr];
		rsp.bias       <= req.bias;
		rsp.last       <= req.last;
	end

	// the external port is only for loading between passes
	assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> !i_weight_valid && !i_data_valid)
		else $error("external memory access during a pass");

endmodule

// ==== rtl/ff_sequencer.sv ====
module ff_sequencer (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      i_data_valid,
	input  logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]  i_data_addr,
	input  logic                                      i_layer_done,
	term_req_if.seq                                   req,
	output logic                                      o_main_net_done
);

	main_net_pkg::seq_state_e                     state;
	main_net_pkg::layer_e                         layer;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]     neuron_cnt;
	logic [main_net_pkg::NODE_ADDR_WIDTH:0]       term_cnt; // reaches fan-in for the bias
	logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]   weight_addr;
	logic                                         start;
	logic                                         bias_term;
	logic                                         last_neuron;

	assign start = i_data_valid &&
		(i_data_addr == main_net_pkg::NODE_ADDR_WIDTH'(main_net_pkg::N_INPUT - 1));
	assign bias_term   = (term_cnt == main_net_pkg::fan_in(layer));
	assign last_neuron = (neuron_cnt == main_net_pkg::layer_nodes(layer) - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= main_net_pkg::SEQ_IDLE;
			layer       <= main_net_pkg::LAYER_HIDDEN_1;
			neuron_cnt  <= '0;
			term_cnt    <= '0;
			weight_addr <= '0;
		end else begin
			case (state)
				main_net_pkg::SEQ_IDLE: begin
					if (start) begin
						state <= main_net_pkg::SEQ_ISSUE;
						layer <= main_net_pkg::LAYER_HIDDEN_1;
					end
				end
				main_net_pkg::SEQ_ISSUE: begin
					weight_addr <= weight_addr + 1'b1; // neuron*(fan_in+1)+term
					if (bias_term) begin
						term_cnt <= '0;
						if (last_neuron) begin
							neuron_cnt <= '0;
							state      <= main_net_pkg::SEQ_WAIT_LAYER;
						end else begin
							neuron_cnt <= neuron_cnt + 1'b1;
						end
					end else begin
						term_cnt <= term_cnt + 1'b1;
					end
				end
				main_net_pkg::SEQ_WAIT_LAYER: begin
					// next layer reads nodes written with layer_done
					if (i_layer_done) begin
						weight_addr <= '0;
						if (layer == main_net_pkg::LAYER_OUTPUT) begin
							state <= main_net_pkg::SEQ_DONE;
						end else begin
							layer <= main_net_pkg::layer_e'(layer + 1'b1);
							state <= main_net_pkg::SEQ_ISSUE;
						end
					end
				end
				main_net_pkg::SEQ_DONE: begin
					state <= main_net_pkg::SEQ_IDLE;
				end
				default: begin
					state <= main_net_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	assign req.valid       = (state == main_net_pkg::SEQ_ISSUE);
	assign req.layer       = layer;
	assign req.term        = term_cnt[main_net_pkg::NODE_ADDR_WIDTH-1:0];
	assign req.weight_addr = weight_addr;
	assign req.bias        = bias_term;
	assign req.last        = bias_term; // bias closes every neuron
	assign o_main_net_done = (state == main_net_pkg::SEQ_DONE);

	assert property (@(posedge clk) disable iff (!rst_n)
		start |-> state == main_net_pkg::SEQ_IDLE)
		else $error("pass started while sequencer busy");

	// layer completion from the accumulator only while waiting on it
	assert property (@(posedge clk) disable iff (!rst_n)
		i_layer_done |-> state == main_net_pkg::SEQ_WAIT_LAYER)
		else $error("layer done outside wait state");

endmodule

// ==== rtl/neuron_accumulator.sv ====
module neuron_accumulator (
	input  logic      clk,
	input  logic      rst_n,
	term_rsp_if.acc   rsp,
	node_wr_if.acc    wr,
	output logic      o_layer_done
);

	logic signed [main_net_pkg::ACC_WIDTH-1:0]    acc;
	logic signed [main_net_pkg::ACC_WIDTH-1:0]    product;
	logic signed [main_net_pkg::ACC_WIDTH-1:0]    acc_sum;
	logic signed [main_net_pkg::DATA_WIDTH-1:0]   bias_w;
	logic signed [main_net_pkg::ACC_WIDTH-1:0]    pre_act;
	logic signed [main_net_pkg::ACC_WIDTH-1:0]    post_act;
	logic [main_net_pkg::DATA_WIDTH-1:0]          sat_data;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]     neuron_cnt;
	logic                                         last_neuron;

	assign product = $signed(rsp.node_value) * $signed(rsp.weight);
	assign acc_sum = rsp.bias ? acc : acc + product;
	assign bias_w  = rsp.bias ? rsp.weight : '0;
	assign pre_act = (acc_sum >>> main_net_pkg::FRAC_BITS) + bias_w; // back to q7.8

	assign last_neuron = (neuron_cnt == main_net_pkg::layer_nodes(rsp.layer) - 1);

	always_comb begin
		post_act = pre_act;
		if (rsp.layer != main_net_pkg::LAYER_OUTPUT && pre_act < 0) begin
			post_act = '0; // relu on hidden layers only
		end
		if (post_act > main_net_pkg::DATA_MAX) begin
			sat_data = main_net_pkg::DATA_WIDTH'(main_net_pkg::DATA_MAX);
		end else if (post_act < main_net_pkg::DATA_MIN) begin
			sat_data = main_net_pkg::DATA_WIDTH'(main_net_pkg::DATA_MIN);
		end else begin
			sat_data = post_act[main_net_pkg::DATA_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc          <= '0;
			neuron_cnt   <= '0;
			wr.valid     <= 1'b0;
			o_layer_done <= 1'b0;
		end else begin
			wr.valid     <= rsp.valid && rsp.last;
			o_layer_done <= rsp.valid && rsp.last && last_neuron;
			if (rsp.valid) begin
				if (rsp.last) begin
					acc        <= '0;
					neuron_cnt <= last_neuron ? '0 : neuron_cnt + 1'b1;
				end else begin
					acc <= acc_sum;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rsp.valid && rsp.last) begin
			wr.layer <= rsp.layer;
			wr.addr  <= neuron_cnt;
			wr.data  <= sat_data;
		end
	end

endmodule

// ==== rtl/argument_max.sv ====
module argument_max (
	input  logic                                      clk,
	input  logic                                      rst_n,
	node_wr_if.mon                                    mon,
	output logic                                      o_arg_max_valid,
	output logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]  o_arg_max,
	output logic [main_net_pkg::DATA_WIDTH-1:0]       o_arg_max_value
);

	logic                                         seen;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]     best_idx;
	logic signed [main_net_pkg::DATA_WIDTH-1:0]   best_value;
	logic                                         out_wr;
	logic                                         out_last;
	logic                                         take;

	assign out_wr   = mon.valid && (mon.layer == main_net_pkg::LAYER_OUTPUT);
	assign out_last = out_wr && (mon.addr == main_net_pkg::N_OUTPUT - 1);
	assign take     = !seen || ($signed(mon.data) > best_value); // tie keeps lower index

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seen            <= 1'b0;
			o_arg_max_valid <= 1'b0;
		end else begin
			o_arg_max_valid <= out_last;
			if (out_wr) begin
				seen <= !out_last; // clear for next pass
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_wr && take) begin
			best_idx   <= mon.addr;
			best_value <= mon.data;
		end
		if (out_last) begin
			o_arg_max       <= take ? mon.addr : best_idx;
			o_arg_max_value <= take ? mon.data : best_value;
		end
	end

endmodule

// ==== rtl/main_net.sv ====
module main_net (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        i_data_valid,
	input  logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]    i_data_addr,
	input  logic [main_net_pkg::DATA_WIDTH-1:0]         i_data,
	input  logic                                        i_weight_valid,
	input  logic                                        i_rw_weight_select,
	input  logic [main_net_pkg::LAYER_WIDTH-1:0]        i_weight_layer,
	input  logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]  i_weight_addr,
	input  logic [main_net_pkg::DATA_WIDTH-1:0]         i_weight,
	output logic                                        o_weight_valid,
	output logic [main_net_pkg::LAYER_WIDTH-1:0]        o_weight_layer,
	output logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]  o_weight_addr,
	output logic [main_net_pkg::DATA_WIDTH-1:0]         o_weight,
	output logic                                        o_arg_max_valid,
	output logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]    o_arg_max,
	output logic [main_net_pkg::DATA_WIDTH-1:0]         o_arg_max_value,
	output logic                                        o_main_net_done
);

	logic layer_done;

	term_req_if req_if ();
	term_rsp_if rsp_if ();
	node_wr_if  wr_if ();

	ff_sequencer sequencer_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_data_valid    (i_data_valid),
		.i_data_addr     (i_data_addr), // last input node starts a pass
		.i_layer_done    (layer_done),
		.req             (req_if.seq),
		.o_main_net_done (o_main_net_done)
	);

	ann_memory memory_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.i_weight_valid     (i_weight_valid),
		.i_rw_weight_select (i_rw_weight_select),
		.i_weight_layer     (i_weight_layer),
		.i_weight_addr      (i_weight_addr),
		.i_weight           (i_weight),
		.i_data_valid       (i_data_valid),
		.i_data_addr        (i_data_addr),
		.i_data             (i_data),
		.o_weight_valid     (o_weight_valid),
		.o_weight_layer     (o_weight_layer),
		.o_weight_addr      (o_weight_addr),
		.o_weight           (o_weight),
		.req                (req_if.mem),
		.rsp                (rsp_if.mem),
		.wr                 (wr_if.mem)
	);

	neuron_accumulator accumulator_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.rsp          (rsp_if.acc),
		.wr           (wr_if.acc),
		.o_layer_done (layer_done)
	);

	argument_max arg_max_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.mon             (wr_if.mon),
		.o_arg_max_valid (o_arg_max_valid),
		.o_arg_max       (o_arg_max),
		.o_arg_max_value (o_arg_max_value)
	);

endmodule

// ==== testbench/tb_main_net.sv ====
module tb_main_net;

	localparam int CLK_PERIOD      = 40;
	localparam int N_WEIGHTS       = 47;
	localparam int N_CASES         = 6;
	localparam int VEC_WORDS       = 3 * N_WEIGHTS + 4 * N_CASES;
	localparam int PASS_CYCLES     = N_WEIGHTS + 32; // issue cycles plus layer turnaround
	localparam int LOAD_CYCLES     = 12 + 6 * N_WEIGHTS;
	localparam int WATCHDOG_CYCLES = 4 * (N_CASES * PASS_CYCLES + LOAD_CYCLES);

	logic                                        clk;
	logic                                        rst_n;
	logic                                        i_data_valid;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]    i_data_addr;
	logic [main_net_pkg::DATA_WIDTH-1:0]         i_data;
	logic                                        i_weight_valid;
	logic                                        i_rw_weight_select;
	logic [main_net_pkg::LAYER_WIDTH-1:0]        i_weight_layer;
	logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]  i_weight_addr;
	logic [main_net_pkg::DATA_WIDTH-1:0]         i_weight;
	logic                                        o_weight_valid;
	logic [main_net_pkg::LAYER_WIDTH-1:0]        o_weight_layer;
	logic [main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]  o_weight_addr;
	logic [main_net_pkg::DATA_WIDTH-1:0]         o_weight;
	logic                                        o_arg_max_valid;
	logic [main_net_pkg::NODE_ADDR_WIDTH-1:0]    o_arg_max;
	logic [main_net_pkg::DATA_WIDTH-1:0]         o_arg_max_value;
	logic                                        o_main_net_done;

	logic [15:0]  vec_mem [VEC_WORDS]; // weights first, then cases
	int           order [N_WEIGHTS];
	int           weight_errors;
	int           pass_errors;
	int           other_errors;
	int unsigned  seed_draw;

	main_net dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic show_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	task automatic write_weight(input int idx);
		@(negedge clk);
		i_weight_valid     = 1'b1;
		i_rw_weight_select = 1'b0;
		i_weight_layer     = vec_mem[3*idx][main_net_pkg::LAYER_WIDTH-1:0];
		i_weight_addr      = vec_mem[3*idx+1][main_net_pkg::WEIGHT_ADDR_WIDTH-1:0];
		i_weight           = vec_mem[3*idx+2];
		@(negedge clk);
		i_weight_valid = 1'b0;
	endtask

	task automatic shuffle_order();
		int j;
		int tmp;
		for (int i = 0; i < N_WEIGHTS; i++) begin
			order[i] = i;
		end
		for (int i = N_WEIGHTS - 1; i > 0; i--) begin
			j        = $urandom % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
	endtask

	task automatic check_readback();
		int idx;
		shuffle_order();
		for (int k = 0; k < N_WEIGHTS; k++) begin
			idx = order[k];
			@(negedge clk);
			if (o_weight_valid !== 1'b0) begin
				$display("o_weight_valid high without a read at t=%0t", $time);
				other_errors++;
			end
			i_weight_valid     = 1'b1;
			i_rw_weight_select = 1'b1;
			i_weight_layer     = vec_mem[3*idx][main_net_pkg::LAYER_WIDTH-1:0];
			i_weight_addr      = vec_mem[3*idx+1][main_net_pkg::WEIGHT_ADDR_WIDTH-1:0];
			@(negedge clk);
			i_weight_valid = 1'b0; // response due one edge after the read
			if (o_weight_valid !== 1'b1) begin
				show_mismatch("o_weight_valid", 1, o_weight_valid);
				weight_errors++;
			end
			if (o_weight_layer !== vec_mem[3*idx][main_net_pkg::LAYER_WIDTH-1:0]) begin
				show_mismatch("o_weight_layer", vec_mem[3*idx], o_weight_layer);
				weight_errors++;
			end
			if (o_weight_addr !== vec_mem[3*idx+1][main_net_pkg::WEIGHT_ADDR_WIDTH-1:0]) begin
				show_mismatch("o_weight_addr", vec_mem[3*idx+1], o_weight_addr);
				weight_errors++;
			end
			if (o_weight !== vec_mem[3*idx+2]) begin
				show_mismatch("o_weight", vec_mem[3*idx+2], o_weight);
				weight_errors++;
			end
		end
	endtask

	task automatic apply_case(input int c);
		int base;
		int waited;
		base   = 3 * N_WEIGHTS + 4 * c;
		waited = 0;
		@(negedge clk);
		i_data_valid = 1'b1;
		i_data_addr  = 0;
		i_data       = vec_mem[base];
		@(negedge clk);
		i_data_addr = 1; // last input node starts the pass
		i_data      = vec_mem[base+1];
		@(negedge clk);
		i_data_valid = 1'b0;
		while (!o_main_net_done && !o_arg_max_valid && waited < PASS_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!o_main_net_done && !o_arg_max_valid) begin
			$display("case %0d: pass did not finish within %0d cycles", c, PASS_CYCLES);
			other_errors++;
		end else begin
			if (o_main_net_done !== 1'b1) begin
				show_mismatch("o_main_net_done", 1, o_main_net_done);
				pass_errors++;
			end
			if (o_arg_max_valid !== 1'b1) begin
				show_mismatch("o_arg_max_valid", 1, o_arg_max_valid);
				pass_errors++;
			end
			if (o_arg_max !== vec_mem[base+2][main_net_pkg::NODE_ADDR_WIDTH-1:0]) begin
				show_mismatch("o_arg_max", vec_mem[base+2], o_arg_max);
				pass_errors++;
			end
			if (o_arg_max_value !== vec_mem[base+3]) begin
				show_mismatch("o_arg_max_value", vec_mem[base+3], o_arg_max_value);
				pass_errors++;
			end
		end
		@(negedge clk);
		if (o_main_net_done !== 1'b0 || o_arg_max_valid !== 1'b0) begin
			$display("case %0d: done or arg-max valid held longer than one cycle", c);
			other_errors++;
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		clk                = 1'b0;
		rst_n              = 1'b0;
		i_data_valid       = 1'b0;
		i_data_addr        = '0;
		i_data             = '0;
		i_weight_valid     = 1'b0;
		i_rw_weight_select = 1'b0;
		i_weight_layer     = '0;
		i_weight_addr      = '0;
		i_weight           = '0;
		weight_errors      = 0;
		pass_errors        = 0;
		other_errors       = 0;
		seed_draw          = $urandom(361);
		$readmemh("testbench/main_net_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[VEC_WORDS-1])) begin
			$display("vector file missing or shorter than expected");
			other_errors++;
		end
		for (int cyc = 0; cyc < 12; cyc++) begin
			@(negedge clk);
			if (cyc == 7) begin
				rst_n = 1'b1;
			end
			if (o_weight_valid !== 1'b0 || o_arg_max_valid !== 1'b0 ||
				o_main_net_done !== 1'b0) begin
				$display("output strobe active before any stimulus at t=%0t", $time);
				other_errors++;
			end
		end
		for (int i = 0; i < N_WEIGHTS; i++) begin
			write_weight(i);
		end
		check_readback();
		for (int c = 0; c < N_CASES; c++) begin
			apply_case(c);
		end
		check_readback(); // passes must leave weights alone
		$display("errors: weight %0d, pass %0d, other %0d", weight_errors, pass_errors,
			other_errors);
		if (weight_errors + pass_errors + other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== testbench/main_net_vectors.txt ====
// weights, one per line: layer  addr  weight (hex, q7.8)
1 00 0100
1 01 0000
1 02 0000
1 03 0000
1 04 0100
1 05 0000
1 06 0080
1 07 0080
1 08 0040
1 09 ff00
1 0a 0100
1 0b 0100
2 00 0100
2 01 0000
2 02 0000
2 03 0000
2 04 0000
2 05 0000
2 06 0100
2 07 0000
2 08 0000
2 09 0000
2 0a 0000
2 0b 0000
2 0c 0100
2 0d 0000
2 0e 0000
2 0f 0080
2 10 0080
2 11 0000
2 12 0100
2 13 ff80
3 00 0200
3 01 0000
3 02 0000
3 03 0000
3 04 0100
3 05 0000
3 06 0200
3 07 0000
3 08 0000
3 09 0100
3 0a 0000
3 0b 0000
3 0c 0100
3 0d 0080
3 0e 0000
// cases: input_0  input_1  expected_index  expected_max (hex)
0000 0000 0 0100
4000 4000 0 7fff
0100 0300 1 0700
ff80 0040 1 0180
0101 ff00 0 0302
fc00 0000 2 0240

// ==== vlog.f ====
rtl/main_net_pkg.sv
rtl/ff_if.sv
rtl/ann_memory.sv
rtl/ff_sequencer.sv
rtl/neuron_accumulator.sv
rtl/argument_max.sv
rtl/main_net.sv
testbench/tb_main_net.sv
